// File: bench/poc_edge_store_asserts.sv
/* Concurrent checks on the edge store load and hold rules */

`timescale 1ns/1ns

module poc_edge_store_asserts
  import poc_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input poc_run_t   run_evt,
  input poc_edges_t edges
);

  logic [TAP_W-1:0] trail_exp;

  // Start of the finished run, folded back into one clock period
  always_comb begin
    if (run_evt.run > run_evt.tap) begin
      trail_exp = TAP_W'(int'(run_evt.tap) + int'(TAPS_PER_KCLK) - int'(run_evt.run));
    end else begin
      trail_exp = TAP_W'(int'(run_evt.tap) - int'(run_evt.run));
    end
  end

  property high_run_load_p;
    @(posedge clk) disable iff (!rst_n)
      (run_evt.run_end && run_evt.polarity) |=>
        (edges.fall_lead == $past(run_evt.tap)) && (edges.rise_trail == $past(trail_exp)) &&
        $stable(edges.rise_lead) && $stable(edges.fall_trail);
  endproperty

  property low_run_load_p;
    @(posedge clk) disable iff (!rst_n)
      (run_evt.run_end && !run_evt.polarity) |=>
        (edges.rise_lead == $past(run_evt.tap)) && (edges.fall_trail == $past(trail_exp)) &&
        $stable(edges.fall_lead) && $stable(edges.rise_trail);
  endproperty

  property hold_p;
    @(posedge clk) disable iff (!rst_n)
      !run_evt.run_end |=> $stable(edges);
  endproperty

  a_high_run_load: assert property (high_run_load_p)
    else $error("Edge store did not load fall_lead and rise_trail on a high run end");
  a_low_run_load: assert property (low_run_load_p)
    else $error("Edge store did not load rise_lead and fall_trail on a low run end");
  a_hold: assert property (hold_p)
    else $error("Edge registers changed without a run end");

endmodule

bind poc_edge_store poc_edge_store_asserts u_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .run_evt (run_evt),
  .edges   (edges)
);

// File: bench/poc_tb.sv
/* Testbench for the POC edge finder
   Sweep generator, reference model, result compare and timeout */

`timescale 1ns/1ns

module poc_tb
  import poc_pkg::*;
;

  logic        clk = 1'b0;
  logic        rst_n;
  poc_sample_t sample;
  poc_result_t result;

  poc_sample_t stim[$];
  poc_result_t exp_res[$];
  string       exp_name[$];
  int          exp_cyc[$];
  poc_edges_t  ref_edges;

  integer      seed;
  int          cycles = 0;
  int          limit = 0;
  int          ntests = 0;
  int          done = 0;
  int          errors = 0;
  int          pulses = 0;

  // Compare process scratch
  poc_result_t want;
  string       cur_name;
  int          cur_cyc;
  bit          ok;
  bit          val_ok;

  poc_top u_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (sample),
    .result (result)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles with %0d of %0d sweeps checked", cycles, done, ntests);
      $display("tests failed");
      $finish;
    end
  end

  // Circular mean rounded down
  function automatic int mean_on_circle(input int lead, input int trail);
    int kclk;
    kclk = int'(TAPS_PER_KCLK);
    if (lead >= trail) begin
      return (lead + trail) / 2;
    end
    return ((lead + trail + kclk) / 2) % kclk;
  endfunction

  // Expected result of one sweep; edge state carries over between sweeps
  function automatic poc_result_t expected_result(input poc_sample_t sw[$]);
    int          cnt;
    int          tap;
    int          trail;
    int          kclk;
    int          rc;
    int          fc;
    bit          first;
    logic        prev;
    poc_result_t r;
    kclk  = int'(TAPS_PER_KCLK);
    cnt   = 0;
    first = 1'b1;
    prev  = 1'b0;
    foreach (sw[i]) begin
      if (sw[i].valid) begin
        if (cnt != 0 && sw[i].level != prev) begin
          if (cnt >= int'(MIN_RUN) && !first) begin
            tap   = int'(sw[i].tap);
            trail = (cnt > tap) ? tap + kclk - cnt : tap - cnt;
            if (prev) begin
              ref_edges.fall_lead  = TAP_W'(tap);
              ref_edges.rise_trail = TAP_W'(trail);
            end else begin
              ref_edges.rise_lead  = TAP_W'(tap);
              ref_edges.fall_trail = TAP_W'(trail);
            end
          end
          cnt   = 1;
          first = 1'b0;
        end else if (cnt < 127) begin
          cnt = cnt + 1;
        end
        prev = sw[i].level;
        if (sw[i].last) begin
          cnt   = 0;
          first = 1'b1;
        end
      end
    end
    rc = mean_on_circle(int'(ref_edges.rise_lead), int'(ref_edges.rise_trail));
    fc = mean_on_circle(int'(ref_edges.fall_lead), int'(ref_edges.fall_trail));
    r.valid       = 1'b1;
    r.rise_center = TAP_W'(rc);
    r.fall_center = TAP_W'(fc);
    r.high_width  = TAP_W'((fc >= rc) ? fc - rc : fc + kclk - rc);
    return r;
  endfunction

  // Square wave sweep, optional two-sample glitch at g1, one-sample glitch at g2,
  // idle cycles after every gap_every samples
  task automatic add_sweep(input string name, input int start, input int rise,
                           input int width, input int g1, input int g2, input int gap_every);
    poc_sample_t cur[$];
    poc_sample_t s;
    int          tap;
    int          off;
    for (int i = 0; i < 112; i++) begin
      tap     = (start + i) % 112;
      off     = (tap - rise + 112) % 112;
      s.valid = 1'b1;
      s.level = (off < width);
      s.tap   = TAP_W'(tap);
      s.last  = (i == 111);
      if ((i >= g1 && i < g1 + 2 && g1 >= 0) || i == g2) begin
        s.level = !s.level;
      end
      cur.push_back(s);
      if (gap_every > 0 && i % gap_every == gap_every - 1 && i != 111) begin
        repeat (1 + i % 2) cur.push_back('0);
      end
    end
    exp_res.push_back(expected_result(cur));
    exp_name.push_back(name);
    foreach (cur[j]) stim.push_back(cur[j]);
  endtask

  task automatic check_result(input poc_result_t got, input poc_result_t exp,
                              input string name, output bit good);
    good = 1'b1;
    if (got.rise_center !== exp.rise_center) begin
      $display("Mismatch at %0t: %s rise_center got %0d expected %0d",
               $time, name, got.rise_center, exp.rise_center);
      good = 1'b0;
    end
    if (got.fall_center !== exp.fall_center) begin
      $display("Mismatch at %0t: %s fall_center got %0d expected %0d",
               $time, name, got.fall_center, exp.fall_center);
      good = 1'b0;
    end
    if (got.high_width !== exp.high_width) begin
      $display("Mismatch at %0t: %s high_width got %0d expected %0d",
               $time, name, got.high_width, exp.high_width);
      good = 1'b0;
    end
  endtask

  // Sample on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (result.valid) begin
        pulses = pulses + 1;
        if (exp_cyc.size() == 0) begin
          $display("Result pulse at %0t arrived with no sweep pending", $time);
          errors = errors + 1;
        end else begin
          cur_name = exp_name.pop_front();
          want     = exp_res.pop_front();
          cur_cyc  = exp_cyc.pop_front();
          ok       = 1'b1;
          if (cur_cyc != cycles) begin
            $display("Result for %s arrived at cycle %0d instead of %0d",
                     cur_name, cycles, cur_cyc);
            ok = 1'b0;
          end
          check_result(result, want, cur_name, val_ok);
          ok = ok & val_ok;
          $display("Test %s: %s", cur_name, ok ? "ok" : "FAILED");
          if (!ok) errors = errors + 1;
          done = done + 1;
        end
      end else if (exp_cyc.size() > 0 && exp_cyc[0] < cycles) begin
        $display("Result for %s never arrived", exp_name[0]);
        void'(exp_name.pop_front());
        void'(exp_res.pop_front());
        void'(exp_cyc.pop_front());
        errors = errors + 1;
        done   = done + 1;
      end
    end
  end

  initial begin
    int start;
    int rise;
    int width;
    seed      = 32'h3f91875e;
    rst_n     = 1'b0;
    sample    = '0;
    ref_edges = '0;

    add_sweep("clean square", 0, 100, 60, -1, -1, 0);
    add_sweep("wraparound", 40, 20, 50, -1, -1, 0);
    // Same sweep with idle cycles, so the same edge history gives the same result
    add_sweep("gaps", 40, 20, 50, -1, -1, 3);
    add_sweep("glitches", 0, 100, 60, 70, 20, 0);
    for (int k = 0; k < 6; k++) begin
      start = {$random(seed)} % 112;
      rise  = {$random(seed)} % 112;
      width = 10 + {$random(seed)} % 90;
      add_sweep($sformatf("random %0d", k), start, rise, width, -1, -1, 0);
    end
    ntests = exp_res.size();
    limit  = stim.size() + 20 * ntests;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (stim[i]) begin
      @(posedge clk);
      sample <= stim[i];
      if (stim[i].valid && stim[i].last) begin
        exp_cyc.push_back(cycles + 4);
      end
    end
    @(posedge clk);
    sample <= '0;

    wait (done == ntests);
    @(posedge clk);
    $display("Checked %0d of %0d sweeps, %0d result pulses, %0d errors",
             done, ntests, pulses, errors);
    if (errors == 0 && pulses == ntests) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: hdl/poc_center_calc.sv
/* Result stage of the POC edge finder
   Circular edge centers and high-phase width, registered at sweep end */

`timescale 1ns/1ns

module poc_center_calc
  import poc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  poc_edges_t  edges,
  input  logic        sweep_end,
  output poc_result_t result
);

  logic [TAP_W-1:0] rise_c;
  logic [TAP_W-1:0] fall_c;
  logic [TAP_W:0]   width_wrap;
  logic [TAP_W-1:0] width;

  logic             valid_q;
  logic [TAP_W-1:0] rise_q;
  logic [TAP_W-1:0] fall_q;
  logic [TAP_W-1:0] width_q;

  // Mean of two taps on the circle, rounded down
  function automatic logic [TAP_W-1:0] circ_mean(input logic [TAP_W-1:0] lead,
                                                 input logic [TAP_W-1:0] trail);
    logic [TAP_W+1:0] sum;
    logic [TAP_W:0]   half;
    sum = {2'b00, lead} + {2'b00, trail};
    // Lead behind trail means the pair straddles tap 0
    if (lead < trail) begin
      sum = sum + {2'b00, TAPS_PER_KCLK};
    end
    half = sum[TAP_W+1:1];
    if (half >= {1'b0, TAPS_PER_KCLK}) begin
      half = half - {1'b0, TAPS_PER_KCLK};
    end
    return half[TAP_W-1:0];
  endfunction

  assign rise_c = circ_mean(edges.rise_lead, edges.rise_trail);
  assign fall_c = circ_mean(edges.fall_lead, edges.fall_trail);

  // Distance from the rising center forward to the falling center
  assign width_wrap = {1'b0, fall_c} + {1'b0, TAPS_PER_KCLK} - {1'b0, rise_c};
  assign width      = (fall_c >= rise_c) ? (fall_c - rise_c) : width_wrap[TAP_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sweep_end;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_end) begin
      rise_q  <= rise_c;
      fall_q  <= fall_c;
      width_q <= width;
    end
  end

  assign result = '{valid: valid_q, rise_center: rise_q, fall_center: fall_q,
                    high_width: width_q};

endmodule

// File: hdl/poc_edge_store.sv
/* Execute stage of the POC edge finder
   Four edge registers, trailing edge with wraparound, delayed sweep end */

`timescale 1ns/1ns

module poc_edge_store
  import poc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  poc_run_t   run_evt,
  output poc_edges_t edges,
  output logic       sweep_end
);

  logic [TAP_W:0]   trail_wrap;
  logic [TAP_W-1:0] trail;

  // Start of the finished run, wrapped into one clock period
  assign trail_wrap = {1'b0, run_evt.tap} + {1'b0, TAPS_PER_KCLK} - {1'b0, run_evt.run};

  always_comb begin
    if (run_evt.run > run_evt.tap) begin
      trail = trail_wrap[TAP_W-1:0];
    end else begin
      trail = run_evt.tap - run_evt.run;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edges     <= '0;
      sweep_end <= 1'b0;
    end else begin
      sweep_end <= run_evt.last;
      if (run_evt.run_end) begin
        if (run_evt.polarity) begin
          // High run ended, so a falling edge here and a rising edge at its start
          edges.fall_lead  <= run_evt.tap;
          edges.rise_trail <= trail;
        end else begin
          edges.rise_lead  <= run_evt.tap;
          edges.fall_trail <= trail;
        end
      end
    end
  end

endmodule

// File: hdl/poc_pkg.sv
/* Shared sizes and packed structs for the POC edge finder
   Sample, run-end event, edge register set and result words */

package poc_pkg;

  // Width of a tap index or a run length
  localparam int TAP_W = 7;

  // One clock period spans this many delay taps
  localparam logic [TAP_W-1:0] TAPS_PER_KCLK = 7'd112;

  // Shortest run that is taken as a real level
  localparam logic [TAP_W-1:0] MIN_RUN = 7'd4;

  // One sweep sample, 10 bits
  typedef struct packed {
    logic             valid;
    logic             level;   // phase detector output
    logic [TAP_W-1:0] tap;     // tap the sample was taken at
    logic             last;    // final sample of the sweep
  } poc_sample_t;

  // Run-end event from the decode stage, 17 bits
  typedef struct packed {
    logic             run_end;   // qualified run end
    logic             polarity;  // level of the run that just finished
    logic [TAP_W-1:0] tap;       // first tap of the new run
    logic [TAP_W-1:0] run;       // length of the finished run
    logic             last;
  } poc_run_t;

  // Edge registers, 28 bits
  // Lead is where the edge was seen, trail is where it is implied by the run length
  typedef struct packed {
    logic [TAP_W-1:0] rise_lead;
    logic [TAP_W-1:0] rise_trail;
    logic [TAP_W-1:0] fall_lead;
    logic [TAP_W-1:0] fall_trail;
  } poc_edges_t;

  // Sweep result, 22 bits
  typedef struct packed {
    logic             valid;        // one-cycle pulse per sweep
    logic [TAP_W-1:0] rise_center;
    logic [TAP_W-1:0] fall_center;
    logic [TAP_W-1:0] high_width;   // taps from rise to fall, circular
  } poc_result_t;

  // Typical flow
  //   sample -> run detector -> run_evt
  //   run_evt -> edge store -> edges, sweep_end
  //   edges, sweep_end -> center calculator -> result
  // All tap arithmetic is modulo TAPS_PER_KCLK

endpackage

// File: hdl/poc_run_detector.sv
/* Decode stage of the POC edge finder
   Counts runs of equal level and flags qualified run ends */

`timescale 1ns/1ns

module poc_run_detector
  import poc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  poc_sample_t sample,
  output poc_run_t    run_evt
);

  logic             prev_level;
  logic [TAP_W-1:0] run_cnt;
  logic             first_run;

  logic             sweep_start;
  logic             level_change;
  logic             run_ok;
  logic             run_end_d;

  // Registered event fields
  logic             run_end_q;
  logic             last_q;
  logic             pol_q;
  logic [TAP_W-1:0] tap_q;
  logic [TAP_W-1:0] run_q;

  // A zero count marks the first sample of a sweep, which has no predecessor
  assign sweep_start  = (run_cnt == '0);
  assign level_change = sample.valid && !sweep_start && (sample.level != prev_level);
  assign run_ok       = (run_cnt >= MIN_RUN);

  // First run of the sweep started at an unknown tap, so it never qualifies
  assign run_end_d = level_change && run_ok && !first_run;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_level <= 1'b0;
      run_cnt    <= '0;
      first_run  <= 1'b1;
      run_end_q  <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      run_end_q <= run_end_d;
      last_q    <= sample.valid & sample.last;
      if (sample.valid) begin
        prev_level <= sample.level;
        if (sample.last) begin
          // Ready for the next sweep on the following cycle
          run_cnt   <= '0;
          first_run <= 1'b1;
        end else if (level_change) begin
          run_cnt   <= 7'd1;
          first_run <= 1'b0;
        end else if (run_cnt != '1) begin
          run_cnt <= run_cnt + 7'd1;  // saturates on an overlong run
        end
      end
    end
  end

  // Event payload, only meaningful alongside run_end
  always_ff @(posedge clk) begin
    if (sample.valid) begin
      pol_q <= prev_level;
      tap_q <= sample.tap;
      run_q <= run_cnt;
    end
  end

  assign run_evt = '{run_end: run_end_q, polarity: pol_q, tap: tap_q,
                     run: run_q, last: last_q};

endmodule

// File: hdl/poc_top.sv
/* Top level of the POC edge finder
   Decode, execute and result stages in a three-cycle pipeline */

`timescale 1ns/1ns

module poc_top
  import poc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  poc_sample_t sample,
  output poc_result_t result
);

  poc_run_t   run_evt;
  poc_edges_t edges;
  logic       sweep_end;

  // Run ends one cycle after the sample
  poc_run_detector u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .sample  (sample),
    .run_evt (run_evt)
  );

  // Edges and sweep end one cycle later
  poc_edge_store u_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_evt   (run_evt),
    .edges     (edges),
    .sweep_end (sweep_end)
  );

  // Result pulse three cycles after the last sample
  poc_center_calc u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .edges     (edges),
    .sweep_end (sweep_end),
    .result    (result)
  );

endmodule

// File: poc_edge.f
hdl/poc_pkg.sv
hdl/poc_run_detector.sv
hdl/poc_edge_store.sv
hdl/poc_center_calc.sv
hdl/poc_top.sv
bench/poc_edge_store_asserts.sv
bench/poc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the POC edge finder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f poc_edge.f --top-module poc_tb -o poc_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/poc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
